//--- ctrlUnit.f
+incdir+hdl
hdl/ctrlPkg.sv
hdl/instrDecoder.sv
hdl/stateSequencer.sv
hdl/controlWordGen.sv
hdl/ctrlUnit.sv
tests/tbClock.sv
tests/ctrlUnit_sva.sv
tests/ctrlUnitTb.sv

//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := ctrlUnitTb
FILELIST  := ctrlUnit.f
OBJDIR    := obj_dir

SIM     := $(OBJDIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST)) $(wildcard hdl/*.svh)

.PHONY: all run clean

all: $(SIM)

# Rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "Test OK"

clean:
	rm -rf $(OBJDIR)

//--- tests/ctrlUnitTb.sv
`default_nettype none

`include "ctrlUnit_cfg.svh"

module ctrlUnitTb;
    import ctrlPkg::*;

    localparam int numInstr = 60;
    localparam int maxWait  = 12;

    logic                         clk;
    logic                         reset;
    logic [`CTRL_INSTR_WIDTH-1:0] instr;
    logic                         pcWrite;
    logic                         irWrite;
    logic                         abWrite;
    logic                         regWrite;
    logic                         aluOutWrite;
    logic                         shiftSrc;
    logic                         aluSrcA;
    aluOp_e                       aluControl;
    shiftOp_e                     shiftControl;
    logic [1:0]                   shiftAmtSel;
    memToReg_e                    memToReg;
    writeRegSel_e                 writeRegSel;
    pcSource_e                    pcSource;
    aluSrcB_e                     aluSrcB;

    tbClock clockGen (.clk(clk));

    ctrlUnit i_dut (.*);

    bind ctrlUnit ctrlUnitSva checks (
        .clk         (clk),
        .reset       (reset),
        .pcWrite     (pcWrite),
        .irWrite     (irWrite),
        .abWrite     (abWrite),
        .regWrite    (regWrite),
        .aluOutWrite (aluOutWrite)
    );

    // Outputs settle right after the edge, inputs change at the same point
    task automatic nextCycle();
        @(posedge clk);
        #1;
    endtask

    task automatic expectEq(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            $display("CHECK FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
            $display("Test FAILED");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic timeoutFail(input string what);
        $display("Timed out waiting for %s", what);
        $display("Test FAILED");
        $fatal(1, "timeout");
    endtask

    function automatic opClass_e classify(input logic [31:0] word);
        if (word[31:26] != `CTRL_OPC_RTYPE) begin
            return opUnknown;
        end
        case (word[5:0])
            `CTRL_FUNCT_ADD:  return opAdd;
            `CTRL_FUNCT_SUB:  return opSub;
            `CTRL_FUNCT_AND:  return opAnd;
            `CTRL_FUNCT_SLL:  return opSll;
            `CTRL_FUNCT_SRA:  return opSra;
            `CTRL_FUNCT_SRL:  return opSrl;
            `CTRL_FUNCT_SLLV: return opSllv;
            `CTRL_FUNCT_SRAV: return opSrav;
            `CTRL_FUNCT_SLT:  return opSlt;
            `CTRL_FUNCT_RTE:  return opRte;
            default:          return opUnknown;
        endcase
    endfunction

    function automatic int expectedInterval(input opClass_e cls);
        case (cls)
            opAdd, opSub, opAnd:                      return 7;
            opSll, opSra, opSrl, opSllv, opSrav:      return 8;
            opSlt, opRte:                             return 6;
            default:                                  return 5;
        endcase
    endfunction

    // Random register fields around a kept, unlisted or non R-type code
    function automatic logic [31:0] randomInstr();
        logic [31:0] rnd;
        logic [5:0]  opcode;
        logic [5:0]  funct;
        int          pick;
        rnd    = $urandom();
        pick   = $urandom_range(0, 13);
        opcode = `CTRL_OPC_RTYPE;
        case (pick)
            0:       funct = `CTRL_FUNCT_ADD;
            1:       funct = `CTRL_FUNCT_SUB;
            2:       funct = `CTRL_FUNCT_AND;
            3:       funct = `CTRL_FUNCT_SLL;
            4:       funct = `CTRL_FUNCT_SRA;
            5:       funct = `CTRL_FUNCT_SRL;
            6:       funct = `CTRL_FUNCT_SLLV;
            7:       funct = `CTRL_FUNCT_SRAV;
            8:       funct = `CTRL_FUNCT_SLT;
            9:       funct = `CTRL_FUNCT_RTE;
            10:      funct = 6'b001000;
            11:      funct = 6'b111111;
            default: begin
                opcode = rnd[31:26] | 6'b000001;
                funct  = `CTRL_FUNCT_ADD;
            end
        endcase
        return {opcode, rnd[25:6], funct};
    endfunction

    // PC + 4 needs the constant four on ALU input B
    task automatic checkFetch();
        expectEq("pcWrite", 32'(pcWrite), 32'(1'b1));
        expectEq("pcSource", 32'(pcSource), 32'(pcAluResult));
        expectEq("aluSrcB", 32'(aluSrcB), 32'(srcBFour));
    endtask

    // k counts cycles since the irWrite of this instruction
    task automatic checkStep(input opClass_e cls, input int k);
        logic     expReg;
        logic     imm;
        aluOp_e   expAlu;
        shiftOp_e expShift;
        expReg   = 1'b0;
        imm      = (cls == opSll) || (cls == opSra) || (cls == opSrl);
        expAlu   = (cls == opSub) ? aluSub : (cls == opAnd) ? aluAnd : aluAdd;
        expShift = (cls == opSll || cls == opSllv) ? shiftLeft :
                   (cls == opSrl) ? shiftRightLogic : shiftRightArith;
        case (cls)
            opAdd, opSub, opAnd: begin
                if (k == 3) begin
                    expectEq("aluOutWrite", 32'(aluOutWrite), 32'(1'b1));
                    expectEq("aluSrcA", 32'(aluSrcA), 32'(1'b1));
                    expectEq("aluControl", 32'(aluControl), 32'(expAlu));
                end
                expReg = (k == 4);
                if (k == 4) begin
                    expectEq("memToReg", 32'(memToReg), 32'(wbAluOut));
                    expectEq("writeRegSel", 32'(writeRegSel), 32'(regRd));
                end
            end
            opSll, opSra, opSrl, opSllv, opSrav: begin
                if (k == 3) begin
                    expectEq("shiftControl", 32'(shiftControl), 32'(shiftLoad));
                    expectEq("shiftSrc", 32'(shiftSrc), 32'(imm));
                    expectEq("shiftAmtSel", 32'(shiftAmtSel), 32'(imm));
                end
                if (k == 4) begin
                    expectEq("shiftControl", 32'(shiftControl), 32'(expShift));
                end
                expReg = (k == 5);
                if (k == 5) begin
                    expectEq("memToReg", 32'(memToReg), 32'(wbShifter));
                    expectEq("writeRegSel", 32'(writeRegSel), 32'(regRd));
                end
            end
            opSlt: begin
                expReg = (k == 3);
                if (k == 3) begin
                    expectEq("aluSrcA", 32'(aluSrcA), 32'(1'b1));
                    expectEq("aluControl", 32'(aluControl), 32'(aluCompare));
                    expectEq("memToReg", 32'(memToReg), 32'(wbLessThan));
                end
            end
            opRte: begin
                if (k == 3) begin
                    expectEq("pcWrite", 32'(pcWrite), 32'(1'b1));
                    expectEq("pcSource", 32'(pcSource), 32'(pcEpc));
                end
            end
            default: begin
            end
        endcase
        expectEq("regWrite", 32'(regWrite), 32'(expReg));
    endtask

    // IR takes the new word in the cycle after irWrite and holds it
    task automatic runInstr(input logic [31:0] word);
        opClass_e cls;
        int       k;
        cls = classify(word);
        k   = 0;
        do begin
            nextCycle();
            k++;
            if (k == 1) begin
                instr = word;
            end
            if (!irWrite) begin
                checkStep(cls, k);
            end
            if (k > maxWait) begin
                timeoutFail("irWrite after an instruction");
            end
        end while (!irWrite);
        expectEq("irWrite interval", k, expectedInterval(cls));
        checkFetch();
    endtask

    initial begin
        int cycles;
        void'($urandom(99));
        reset = 1'b1;
        instr = '0;
        repeat (4) @(posedge clk);
        #1;
        reset = 1'b0;

        // Stack pointer init comes first
        nextCycle();
        expectEq("regWrite", 32'(regWrite), 32'(1'b1));
        expectEq("writeRegSel", 32'(writeRegSel), 32'(regStack));
        expectEq("memToReg", 32'(memToReg), 32'(wbStackInit));

        cycles = 0;
        do begin
            nextCycle();
            cycles++;
            if (cycles > maxWait) begin
                timeoutFail("the first irWrite");
            end
        end while (!irWrite);
        expectEq("first irWrite delay", cycles, 2);
        checkFetch();

        for (int i = 0; i < numInstr; i++) begin
            runInstr(randomInstr());
        end

        $display("Test OK");
        $finish;
    end

endmodule

`default_nettype wire

//--- tests/ctrlUnit_sva.sv
`default_nettype none

module ctrlUnitSva (
    input logic clk,
    input logic reset,
    input logic pcWrite,
    input logic irWrite,
    input logic abWrite,
    input logic regWrite,
    input logic aluOutWrite
);

    // Fetch loads the IR and advances the PC together
    irWithPcWrite: assert property (@(posedge clk) irWrite |-> pcWrite)
        else $error("irWrite raised without pcWrite");

    // Register operands are latched right after the fetch
    abAfterIr: assert property (@(posedge clk) irWrite |=> abWrite)
        else $error("abWrite missing in the cycle after irWrite");

    noBackToBackRegWrite: assert property (@(posedge clk) regWrite |=> !regWrite)
        else $error("regWrite high on two consecutive cycles");

    // First reset edge only parks the state, so check from the second one
    idleInReset: assert property (@(posedge clk)
        reset && $past(reset) |-> !(pcWrite || irWrite || abWrite || regWrite || aluOutWrite))
        else $error("strobe active while reset is high");

endmodule

`default_nettype wire

//--- tests/tbClock.sv
`default_nettype none

module tbClock #(
    parameter int halfPeriod = 5
) (
    output logic clk
);

    // Free-running, first rising edge after half a period
    initial begin
        clk = 1'b0;
        forever #halfPeriod clk = ~clk;
    end

endmodule

`default_nettype wire

//--- hdl/ctrlUnit.sv
`default_nettype none

`include "ctrlUnit_cfg.svh"

module ctrlUnit (
    input  logic                         clk,
    input  logic                         reset,
    input  logic [`CTRL_INSTR_WIDTH-1:0] instr,
    output logic                         pcWrite,
    output logic                         irWrite,
    output logic                         abWrite,
    output logic                         regWrite,
    output logic                         aluOutWrite,
    output logic                         shiftSrc,
    output logic                         aluSrcA,
    output ctrlPkg::aluOp_e              aluControl,
    output ctrlPkg::shiftOp_e            shiftControl,
    output logic [1:0]                   shiftAmtSel,
    output ctrlPkg::memToReg_e           memToReg,
    output ctrlPkg::writeRegSel_e        writeRegSel,
    output ctrlPkg::pcSource_e           pcSource,
    output ctrlPkg::aluSrcB_e            aluSrcB
);
    import ctrlPkg::*;

    opClass_e   opClass;
    ctrlState_e state;

    instrDecoder decoder (
        .instr   (instr),
        .opClass (opClass)
    );

    stateSequencer sequencer (
        .clk     (clk),
        .reset   (reset),
        .opClass (opClass),
        .state   (state)
    );

    controlWordGen controlWords (
        .state        (state),
        .pcWrite      (pcWrite),
        .irWrite      (irWrite),
        .abWrite      (abWrite),
        .regWrite     (regWrite),
        .aluOutWrite  (aluOutWrite),
        .shiftSrc     (shiftSrc),
        .aluSrcA      (aluSrcA),
        .aluControl   (aluControl),
        .shiftControl (shiftControl),
        .shiftAmtSel  (shiftAmtSel),
        .memToReg     (memToReg),
        .writeRegSel  (writeRegSel),
        .pcSource     (pcSource),
        .aluSrcB      (aluSrcB)
    );

endmodule

`default_nettype wire

//--- hdl/controlWordGen.sv
`default_nettype none

module controlWordGen (
    input  ctrlPkg::ctrlState_e   state,
    output logic                  pcWrite,
    output logic                  irWrite,
    output logic                  abWrite,
    output logic                  regWrite,
    output logic                  aluOutWrite,
    output logic                  shiftSrc,
    output logic                  aluSrcA,
    output ctrlPkg::aluOp_e       aluControl,
    output ctrlPkg::shiftOp_e     shiftControl,
    output logic [1:0]            shiftAmtSel,
    output ctrlPkg::memToReg_e    memToReg,
    output ctrlPkg::writeRegSel_e writeRegSel,
    output ctrlPkg::pcSource_e    pcSource,
    output ctrlPkg::aluSrcB_e     aluSrcB
);
    import ctrlPkg::*;

    // Shift amount taken from register B or from the shamt field
    localparam logic [1:0] shamtFromReg   = 2'b00;
    localparam logic [1:0] shamtFromInstr = 2'b01;

    always_comb begin
        // Everything idle unless the state says otherwise
        pcWrite      = 1'b0;
        irWrite      = 1'b0;
        abWrite      = 1'b0;
        regWrite     = 1'b0;
        aluOutWrite  = 1'b0;
        shiftSrc     = 1'b0;
        aluSrcA      = 1'b0;
        aluControl   = aluPass;
        shiftControl = shiftNone;
        shiftAmtSel  = shamtFromReg;
        memToReg     = wbMemData;
        writeRegSel  = regRt;
        pcSource     = pcAluOut;
        aluSrcB      = srcBRegB;

        case (state)
            initStack: begin
                regWrite    = 1'b1;
                writeRegSel = regStack;
                memToReg    = wbStackInit;
            end
            fetch1: begin
                aluSrcB    = srcBFour;
                aluControl = aluAdd;
            end
            // PC + 4 goes straight back into the PC
            fetch2: begin
                aluSrcB    = srcBFour;
                aluControl = aluAdd;
                pcWrite    = 1'b1;
                irWrite    = 1'b1;
                pcSource   = pcAluResult;
            end
            decode1: begin
                abWrite     = 1'b1;
                aluSrcB     = srcBBranchOffset;
                aluControl  = aluAdd;
                aluOutWrite = 1'b1;
            end
            decode2: begin
                abWrite    = 1'b1;
                aluSrcB    = srcBBranchOffset;
                aluControl = aluAdd;
            end
            addExec,
            subExec,
            andExec: begin
                aluSrcA     = 1'b1;
                aluOutWrite = 1'b1;
                case (state)
                    subExec: aluControl = aluSub;
                    andExec: aluControl = aluAnd;
                    default: aluControl = aluAdd;
                endcase
            end
            closeArith: begin
                regWrite    = 1'b1;
                writeRegSel = regRd;
                memToReg    = wbAluOut;
            end
            shiftLoadShamt: begin
                shiftControl = shiftLoad;
                shiftSrc     = 1'b1;
                shiftAmtSel  = shamtFromInstr;
            end
            shiftLoadReg: begin
                shiftControl = shiftLoad;
            end
            shiftSll,
            shiftSllv: begin
                shiftControl = shiftLeft;
            end
            shiftSrl: begin
                shiftControl = shiftRightLogic;
            end
            shiftSra,
            shiftSrav: begin
                shiftControl = shiftRightArith;
            end
            shiftEnd: begin
                regWrite    = 1'b1;
                writeRegSel = regRd;
                memToReg    = wbShifter;
            end
            // Compare and write back in the same cycle
            setLess: begin
                aluSrcA     = 1'b1;
                aluControl  = aluCompare;
                regWrite    = 1'b1;
                writeRegSel = regRd;
                memToReg    = wbLessThan;
            end
            returnExc: begin
                pcWrite  = 1'b1;
                pcSource = pcEpc;
            end
            default: begin
            end
        endcase
    end

endmodule

`default_nettype wire

//--- hdl/stateSequencer.sv
`default_nettype none

module stateSequencer (
    input  logic                clk,
    input  logic                reset,
    input  ctrlPkg::opClass_e   opClass,
    output ctrlPkg::ctrlState_e state
);
    import ctrlPkg::*;

    ctrlState_e nextState;
    logic       started;

    // Parked in closeWrite during reset, so every control line stays idle.
    // The first clock out of reset enters initStack.
    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= closeWrite;
            started <= 1'b0;
        end else begin
            state   <= nextState;
            started <= 1'b1;
        end
    end

    always_comb begin
        case (state)
            initStack:  nextState = fetch1;
            fetch1:     nextState = fetch2;
            fetch2:     nextState = decode1;
            decode1:    nextState = decode2;

            // Instruction register is stable here
            decode2: begin
                case (opClass)
                    opAdd:   nextState = addExec;
                    opSub:   nextState = subExec;
                    opAnd:   nextState = andExec;
                    opSll,
                    opSra,
                    opSrl:   nextState = shiftLoadShamt;
                    opSllv,
                    opSrav:  nextState = shiftLoadReg;
                    opSlt:   nextState = setLess;
                    opRte:   nextState = returnExc;
                    default: nextState = closeWrite;
                endcase
            end

            addExec,
            subExec,
            andExec:    nextState = closeArith;
            closeArith: nextState = closeWrite;

            shiftLoadShamt: begin
                case (opClass)
                    opSll:   nextState = shiftSll;
                    opSra:   nextState = shiftSra;
                    opSrl:   nextState = shiftSrl;
                    default: nextState = closeWrite;
                endcase
            end

            shiftLoadReg: begin
                case (opClass)
                    opSllv:  nextState = shiftSllv;
                    opSrav:  nextState = shiftSrav;
                    default: nextState = closeWrite;
                endcase
            end

            shiftSll,
            shiftSra,
            shiftSrl,
            shiftSllv,
            shiftSrav:  nextState = shiftEnd;
            shiftEnd:   nextState = closeWrite;

            setLess,
            returnExc:  nextState = closeWrite;

            // Leaving reset goes through the stack init first
            closeWrite: nextState = started ? fetch1 : initStack;
            default:    nextState = closeWrite;
        endcase
    end

endmodule

`default_nettype wire

//--- hdl/instrDecoder.sv
`default_nettype none

`include "ctrlUnit_cfg.svh"

module instrDecoder (
    input  logic [`CTRL_INSTR_WIDTH-1:0] instr,
    output ctrlPkg::opClass_e            opClass
);
    import ctrlPkg::*;

    logic [`CTRL_OPCODE_WIDTH-1:0] opcode;
    logic [`CTRL_FUNCT_WIDTH-1:0]  funct;

    // Opcode sits in the top bits, function in the bottom bits
    assign opcode = instr[`CTRL_INSTR_WIDTH-1 -: `CTRL_OPCODE_WIDTH];
    assign funct  = instr[`CTRL_FUNCT_WIDTH-1:0];

    always_comb begin
        opClass = opUnknown;
        if (opcode == `CTRL_OPC_RTYPE) begin
            case (funct)
                `CTRL_FUNCT_ADD: begin
                    opClass = opAdd;
                end
                `CTRL_FUNCT_SUB: begin
                    opClass = opSub;
                end
                `CTRL_FUNCT_AND: begin
                    opClass = opAnd;
                end
                `CTRL_FUNCT_SLL: begin
                    opClass = opSll;
                end
                `CTRL_FUNCT_SRA: begin
                    opClass = opSra;
                end
                `CTRL_FUNCT_SRL: begin
                    opClass = opSrl;
                end
                `CTRL_FUNCT_SLLV: begin
                    opClass = opSllv;
                end
                `CTRL_FUNCT_SRAV: begin
                    opClass = opSrav;
                end
                `CTRL_FUNCT_SLT: begin
                    opClass = opSlt;
                end
                `CTRL_FUNCT_RTE: begin
                    opClass = opRte;
                end
                default: begin
                    opClass = opUnknown;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- hdl/ctrlPkg.sv
`default_nettype none

package ctrlPkg;

    // Sequencer states
    // ALU execute states carry an Exec suffix, the plain names belong to aluOp_e
    typedef enum logic [4:0] {
        initStack,
        fetch1,
        fetch2,
        decode1,
        decode2,
        addExec,
        subExec,
        andExec,
        closeArith,
        shiftLoadShamt,
        shiftLoadReg,
        shiftSll,
        shiftSra,
        shiftSrl,
        shiftSllv,
        shiftSrav,
        shiftEnd,
        setLess,
        returnExc,
        closeWrite
    } ctrlState_e;

    typedef enum logic [3:0] {
        opAdd, opSub, opAnd,
        opSll, opSra, opSrl,
        opSllv, opSrav,
        opSlt, opRte,
        opUnknown
    } opClass_e;

    typedef enum logic [2:0] {
        aluPass    = 3'b000,
        aluAdd     = 3'b001,
        aluSub     = 3'b010,
        aluAnd     = 3'b011,
        aluCompare = 3'b111
    } aluOp_e;

    typedef enum logic [2:0] {
        shiftNone       = 3'b000,
        shiftLoad       = 3'b001,
        shiftLeft       = 3'b010,
        shiftRightLogic = 3'b011,
        shiftRightArith = 3'b100
    } shiftOp_e;

    // Write-back source into the register file
    typedef enum logic [3:0] {
        wbMemData   = 4'd0,
        wbAluOut    = 4'd5,
        wbShifter   = 4'd6,
        wbLessThan  = 4'd7,
        wbStackInit = 4'd8
    } memToReg_e;

    typedef enum logic [1:0] {
        regRt    = 2'b00,
        regRd    = 2'b01,
        regStack = 2'b10
    } writeRegSel_e;

    typedef enum logic [1:0] {
        pcAluOut    = 2'b00,
        pcEpc       = 2'b01,
        pcAluResult = 2'b10
    } pcSource_e;

    typedef enum logic [1:0] {
        srcBRegB         = 2'b00,
        srcBFour         = 2'b01,
        srcBBranchOffset = 2'b10
    } aluSrcB_e;

endpackage

`default_nettype wire

//--- hdl/ctrlUnit_cfg.svh
`ifndef CTRL_UNIT_CFG_SVH
`define CTRL_UNIT_CFG_SVH

// Instruction word and field widths
`define CTRL_INSTR_WIDTH     32
`define CTRL_OPCODE_WIDTH    6
`define CTRL_FUNCT_WIDTH     6
`define CTRL_REG_ADDR_WIDTH  5

// Opcode shared by every R-type instruction
`define CTRL_OPC_RTYPE       6'b000000

// R-type function codes
`define CTRL_FUNCT_ADD       6'b100000
`define CTRL_FUNCT_SUB       6'b100010
`define CTRL_FUNCT_AND       6'b100100
`define CTRL_FUNCT_SLL       6'b000000
`define CTRL_FUNCT_SRA       6'b000011
`define CTRL_FUNCT_SRL       6'b000010
`define CTRL_FUNCT_SLLV      6'b000100
`define CTRL_FUNCT_SRAV      6'b000111
`define CTRL_FUNCT_SLT       6'b101010
`define CTRL_FUNCT_RTE       6'b010011

// Stack pointer register, loaded once after reset
`define CTRL_STACK_REG       5'd30

`endif
